/* filelist.f */
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/instDecoder.sv
rtl/immGen.sv
rtl/renameTable.sv
rtl/decodeCtrl.sv
rtl/decodeStage.sv
tb/decodeStage_checker.sv
tb/decodeStageTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim build clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* tb/decodeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb
    import isaPkg::*;
    import pipePkg::*;
;

    localparam int ClkPeriod  = 4;
    localparam int StallLimit = 20;
    // Cycle budget per test: reset, decode, rename, commit, back-pressure, flush.
    localparam int TestCycles = 12 + 150 + 60 + 60 + 160 + 40;
    localparam int TimeoutNs  = (TestCycles + 200) * ClkPeriod;

    logic         clk = 1'b0;
    logic         rst, rdy, instEn, predTaken, commitEn, flush;
    instWord_t    inst;
    addr_t        pc;
    commitInfo_t  commit;
    logic         instStall, issueEn;
    issueBundle_t issue;

    int           errors = 0;
    int           tests = 0;
    logic [31:0]  seed = 32'h8d7f_a052;
    addr_t        pcNow = 32'h0000_1000;
    logic [31:0]  busyM = '0;   // Reference rename table.
    robTag_t      tagM [32];
    robTag_t      nextTag = '0;
    commitInfo_t  pend [$];     // Issued, not yet committed, in tag order.
    issueBundle_t lastIssue;

    decodeStage u_dut (
        .clk (clk), .rst (rst), .rdy (rdy), .instEn (instEn), .inst (inst), .pc (pc),
        .predTaken (predTaken), .commitEn (commitEn), .commit (commit), .flush (flush),
        .instStall (instStall), .issueEn (issueEn), .issue (issue)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    initial begin
        #(TimeoutNs);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    function logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic regName_t rg();   // Random nonzero register.
        logic [31:0] r;
        r = nextRand();
        return regName_t'(r[31:16] % 16'd31 + 16'd1);
    endfunction

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        $display("%s: %s", name, (errors == errBefore) ? "ok" : "failed");
        tests++;
    endtask

    // Called in the cycle after accept; compares, then books the accept in the model.
    task automatic checkIssue(input instWord_t w, input addr_t p, input logic pt,
                              input op_t eop, input imm_t eimm);
        regName_t rd, rs1, rs2;
        rd = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        lastIssue = issue;
        checkField("issueEn", 32'(issueEn), 32'd1);
        checkField("issue.op", 32'(issue.op), 32'(eop));
        checkField("issue.rd", 32'(issue.rd), 32'(rd));
        checkField("issue.rs1", 32'(issue.rs1), 32'(rs1));
        checkField("issue.rs2", 32'(issue.rs2), 32'(rs2));
        checkField("issue.imm", issue.imm, eimm);
        checkField("issue.pc", issue.pc, p);
        checkField("issue.predTaken", 32'(issue.predTaken), 32'(pt));
        checkField("issue.robTag", 32'(issue.robTag), 32'(nextTag));
        checkField("issue.rs1Stat.busy", 32'(issue.rs1Stat.busy), 32'(rs1 != 5'd0 && busyM[rs1]));
        if (rs1 != 5'd0 && busyM[rs1])
            checkField("issue.rs1Stat.tag", 32'(issue.rs1Stat.tag), 32'(tagM[rs1]));
        checkField("issue.rs2Stat.busy", 32'(issue.rs2Stat.busy), 32'(rs2 != 5'd0 && busyM[rs2]));
        if (rs2 != 5'd0 && busyM[rs2])
            checkField("issue.rs2Stat.tag", 32'(issue.rs2Stat.tag), 32'(tagM[rs2]));
        if (rd != 5'd0) begin
            busyM[rd] = 1'b1;
            tagM[rd] = nextTag;
        end
        pend.push_back({rd, nextTag});
        nextTag = nextTag + 3'd1;
    endtask

    task automatic runInst(input instWord_t w, input op_t eop, input imm_t eimm);
        addr_t p;
        logic  pt;
        int    n;
        p = pcNow;
        pcNow = pcNow + 32'd4;
        pt = nextRand() >= 32'h8000_0000;
        @(posedge clk);
        instEn <= 1'b1;
        inst <= w;
        pc <= p;
        predTaken <= pt;
        n = 0;
        @(negedge clk);
        while (instStall && n < StallLimit) begin
            @(negedge clk);
            n++;
        end
        if (instStall) begin
            $display("instruction at pc %h was never accepted", p);
            errors++;
            @(posedge clk) instEn <= 1'b0;
        end else begin
            @(posedge clk) instEn <= 1'b0;
            @(negedge clk);
            checkIssue(w, p, pt, eop, eimm);
        end
    endtask

    task automatic commitOldest();
        commitInfo_t c;
        if (pend.size() == 0)
            return;
        c = pend.pop_front();
        @(posedge clk);
        commitEn <= 1'b1;
        commit <= c;
        @(posedge clk) commitEn <= 1'b0;
        if (busyM[c.rd] && tagM[c.rd] == c.tag)
            busyM[c.rd] = 1'b0;
    endtask

    task automatic drain();
        while (pend.size() > 0)
            commitOldest();
    endtask

    task automatic checkResetState();
        int e;
        e = errors;
        // Fetch strobe is high here, so only reset keeps issue low.
        repeat (3) begin
            @(negedge clk);
            checkField("issueEn", 32'(issueEn), 32'd0);
            checkField("instStall", 32'(instStall), 32'd0);
        end
        @(posedge clk) instEn <= 1'b0;
        @(negedge clk);
        checkField("issueEn", 32'(issueEn), 32'd0);
        checkField("instStall", 32'(instStall), 32'd0);
        @(posedge clk) rst <= 1'b0;
        @(negedge clk);
        checkField("issueEn", 32'(issueEn), 32'd0);
        checkField("instStall", 32'(instStall), 32'd0);
        reportTest("reset", e);
    endtask

    task automatic decodeEachClass();
        logic [31:0] r;
        int e;
        e = errors;
        r = nextRand();
        runInst({r[31:12], rg(), OpcLui}, OpLui, {r[31:12], 12'b0});
        r = nextRand();
        runInst({r[31:12], rg(), OpcAuipc}, OpAuipc, {r[31:12], 12'b0});
        r = nextRand();
        runInst({r[20], r[10:1], r[11], r[19:12], rg(), OpcJal}, OpJal,
                {{11{r[20]}}, r[20:1], 1'b0});
        r = nextRand();
        runInst({r[11:0], rg(), 3'b000, rg(), OpcJalr}, OpJalr, {{20{r[11]}}, r[11:0]});
        r = nextRand();
        runInst({r[12], r[10:5], rg(), rg(), 3'b001, r[4:1], r[11], OpcBranch}, OpBne,
                {{19{r[12]}}, r[12:1], 1'b0});
        drain();
        r = nextRand();
        runInst({r[11:0], rg(), 3'b010, rg(), OpcLoad}, OpLw, {{20{r[11]}}, r[11:0]});
        r = nextRand();
        runInst({r[11:5], rg(), rg(), 3'b001, r[4:0], OpcStore}, OpSh, {{20{r[11]}}, r[11:0]});
        r = nextRand();
        runInst({r[11:0], rg(), 3'b100, rg(), OpcOpImm}, OpXori, {{20{r[11]}}, r[11:0]});
        r = nextRand();
        runInst({7'b0100000, r[4:0], rg(), 3'b101, rg(), OpcOpImm}, OpSrai,
                {20'b0, 7'b0100000, r[4:0]});
        runInst({7'b0100000, rg(), rg(), 3'b000, rg(), OpcOp}, OpSub, '0);
        drain();
        // Unsupported funct3 values.
        r = nextRand();
        runInst({r[12], r[10:5], rg(), rg(), 3'b010, r[4:1], r[11], OpcBranch}, OpNop,
                {{19{r[12]}}, r[12:1], 1'b0});
        runInst({r[11:0], rg(), 3'b011, rg(), OpcLoad}, OpNop, {{20{r[11]}}, r[11:0]});
        drain();
        reportTest("decode", e);
    endtask

    task automatic renameSources();
        regName_t rw;
        robTag_t  t;
        int e;
        e = errors;
        rw = rg();
        runInst({12'h010, rg(), 3'b000, rw, OpcOpImm}, OpAddi, 32'h10);
        t = lastIssue.robTag;
        runInst({7'b0, rg(), rw, 3'b000, rg(), OpcOp}, OpAdd, '0);
        if (!lastIssue.rs1Stat.busy || lastIssue.rs1Stat.tag != t) begin
            $display("reader of x%0d did not wait on tag %0d", rw, t);
            errors++;
        end
        checkField("issue.robTag", 32'(lastIssue.robTag), 32'(t + 3'd1));
        runInst({12'h7ff, rg(), 3'b000, 5'd0, OpcOpImm}, OpAddi, 32'h7ff);
        runInst({7'b0, 5'd0, 5'd0, 3'b000, rg(), OpcOp}, OpAdd, '0);
        checkField("issue.rs1Stat.busy", 32'(lastIssue.rs1Stat.busy), 32'd0);
        drain();
        reportTest("rename", e);
    endtask

    task automatic retireCommits();
        regName_t rw;
        robTag_t  t2;
        int e;
        e = errors;
        rw = rg();
        runInst({12'h001, rg(), 3'b000, rw, OpcOpImm}, OpAddi, 32'h1);
        drain();
        runInst({7'b0, rg(), rw, 3'b111, rg(), OpcOp}, OpAnd, '0);
        checkField("issue.rs1Stat.busy", 32'(lastIssue.rs1Stat.busy), 32'd0);
        drain();
        runInst({12'h002, rg(), 3'b000, rw, OpcOpImm}, OpAddi, 32'h2);
        runInst({12'h003, rg(), 3'b000, rw, OpcOpImm}, OpAddi, 32'h3);
        t2 = lastIssue.robTag;
        commitOldest();   // Stale tag, rw stays busy.
        runInst({7'b0, rg(), rw, 3'b110, rg(), OpcOp}, OpOr, '0);
        if (!lastIssue.rs1Stat.busy || lastIssue.rs1Stat.tag != t2) begin
            $display("stale commit released x%0d", rw);
            errors++;
        end
        drain();
        reportTest("commit", e);
    endtask

    task automatic fillRob();
        instWord_t w;
        addr_t     p;
        int e;
        e = errors;
        // Bring the tag pointer to 0 so the held word wraps onto tag 0.
        while (nextTag != 3'd0)
            runInst({12'h000, 5'd0, 3'b000, 5'd0, OpcOpImm}, OpAddi, '0);
        drain();
        repeat (8) runInst({12'h055, rg(), 3'b000, rg(), OpcOpImm}, OpAddi, 32'h55);
        w = {12'h123, rg(), 3'b000, rg(), OpcOpImm};
        p = pcNow;
        pcNow = pcNow + 32'd4;
        @(posedge clk);
        instEn <= 1'b1;
        inst <= w;
        pc <= p;
        predTaken <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkField("instStall", 32'(instStall), 32'd1);
            checkField("issueEn", 32'(issueEn), 32'd0);
        end
        commitOldest();
        @(negedge clk);
        checkField("instStall", 32'(instStall), 32'd0);
        @(posedge clk) instEn <= 1'b0;
        @(negedge clk);
        checkIssue(w, p, 1'b0, OpAddi, 32'h123);
        checkField("issue.robTag", 32'(lastIssue.robTag), 32'd0);
        drain();
        // Global hold.
        w = {12'h0aa, rg(), 3'b000, rg(), OpcOpImm};
        p = pcNow;
        pcNow = pcNow + 32'd4;
        @(posedge clk);
        rdy <= 1'b0;
        instEn <= 1'b1;
        inst <= w;
        pc <= p;
        predTaken <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkField("instStall", 32'(instStall), 32'd1);
            checkField("issueEn", 32'(issueEn), 32'd0);
        end
        @(posedge clk) rdy <= 1'b1;
        @(negedge clk);
        checkField("instStall", 32'(instStall), 32'd0);
        @(posedge clk) instEn <= 1'b0;
        @(negedge clk);
        checkIssue(w, p, 1'b1, OpAddi, 32'h0aa);
        drain();
        reportTest("back-pressure", e);
    endtask

    task automatic flushSpeculation();
        regName_t  rw;
        instWord_t w;
        addr_t     p;
        int e;
        e = errors;
        rw = rg();
        runInst({12'h004, rg(), 3'b000, rw, OpcOpImm}, OpAddi, 32'h4);
        w = {7'b0, rg(), rw, 3'b100, rg(), OpcOp};
        p = pcNow;
        pcNow = pcNow + 32'd4;
        @(posedge clk);
        flush <= 1'b1;
        instEn <= 1'b1;
        inst <= w;
        pc <= p;
        predTaken <= 1'b1;
        @(negedge clk);
        checkField("instStall", 32'(instStall), 32'd1);
        @(posedge clk) flush <= 1'b0;
        busyM = '0;
        nextTag = '0;
        pend.delete();
        @(negedge clk);
        checkField("issueEn", 32'(issueEn), 32'd0);
        @(posedge clk) instEn <= 1'b0;
        @(negedge clk);
        checkIssue(w, p, 1'b1, OpXor, '0);
        checkField("issue.robTag", 32'(lastIssue.robTag), 32'd0);
        checkField("issue.rs1Stat.busy", 32'(lastIssue.rs1Stat.busy), 32'd0);
        drain();
        reportTest("flush", e);
    endtask

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        instEn = 1'b1;
        inst = '0;
        pc = '0;
        predTaken = 1'b0;
        commitEn = 1'b0;
        commit = '0;
        flush = 1'b0;
        checkResetState();
        decodeEachClass();
        renameSources();
        retireCommits();
        fillRob();
        flushSpeculation();
        $display("summary: %0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/decodeStage_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStageChecker (
    input wire clk,
    input wire rst,
    input wire accept,
    input wire instEn,
    input wire instStall,
    input wire issueEn
);

    // No issue straight out of reset.
    assert property (@(posedge clk) rst |=> !issueEn)
        else $error("issueEn high in the cycle after reset");

    // Issue is exactly one cycle behind accept.
    assert property (@(posedge clk) disable iff (rst) accept |=> issueEn)
        else $error("accept not followed by issueEn");
    assert property (@(posedge clk) disable iff (rst) !accept |=> !issueEn)
        else $error("issueEn without a prior accept");

    assert property (@(posedge clk) instStall |-> instEn)
        else $error("instStall high while instEn is low");

endmodule

bind decodeStage decodeStageChecker u_checker (
    .clk       (clk),
    .rst       (rst),
    .accept    (accept),
    .instEn    (instEn),
    .instStall (instStall),
    .issueEn   (issueEn)
);

`default_nettype wire

/* rtl/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              rdy,
    input  wire              instEn,
    input  wire instWord_t   inst,
    input  wire addr_t       pc,
    input  wire              predTaken,
    input  wire              commitEn,
    input  wire commitInfo_t commit,
    input  wire              flush,
    output logic             instStall,
    output logic             issueEn,
    output issueBundle_t     issue
);

    decodeInfo_t info;
    imm_t        imm;
    srcStatus_t  rs1Stat;
    srcStatus_t  rs2Stat;
    logic        accept;
    robTag_t     allocTag;

    instDecoder u_instDecoder (
        .inst (inst),
        .info (info)
    );

    immGen u_immGen (
        .inst (inst),
        .imm  (imm)
    );

    // Sources see the table as it was before this edge.
    renameTable u_renameTable (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .flush    (flush),
        .accept   (accept),
        .rd       (info.rd),
        .allocTag (allocTag),
        .rs1      (info.rs1),
        .rs2      (info.rs2),
        .commitEn (commitEn),
        .commit   (commit),
        .rs1Stat  (rs1Stat),
        .rs2Stat  (rs2Stat)
    );

    decodeCtrl u_decodeCtrl (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .flush     (flush),
        .instEn    (instEn),
        .pc        (pc),
        .predTaken (predTaken),
        .info      (info),
        .imm       (imm),
        .rs1Stat   (rs1Stat),
        .rs2Stat   (rs2Stat),
        .commitEn  (commitEn),
        .accept    (accept),
        .allocTag  (allocTag),
        .instStall (instStall),
        .issueEn   (issueEn),
        .issue     (issue)
    );

endmodule

`default_nettype wire

/* rtl/decodeCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeCtrl
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              rdy,
    input  wire              flush,
    input  wire              instEn,
    input  wire addr_t       pc,
    input  wire              predTaken,
    input  wire decodeInfo_t info,
    input  wire imm_t        imm,
    input  wire srcStatus_t  rs1Stat,
    input  wire srcStatus_t  rs2Stat,
    input  wire              commitEn,
    output logic             accept,
    output robTag_t          allocTag,
    output logic             instStall,
    output logic             issueEn,
    output issueBundle_t     issue
);

    robCount_t robCount;

    assign accept    = rdy && instEn && !flush && (robCount < robCount_t'(RobDepth));
    assign instStall = instEn && !accept;   // Fetch holds its word.

    always_ff @(posedge clk) begin
        if (rst || (rdy && flush)) begin
            allocTag <= '0;
            robCount <= '0;
        end else if (rdy) begin
            if (accept)
                allocTag <= allocTag + 1'b1;   // Wraps after 7.
            case ({accept, commitEn})
                2'b10:   robCount <= robCount + 1'b1;
                2'b01:   robCount <= robCount - 1'b1;
                default: robCount <= robCount;
            endcase
        end
    end

    // Accept already excludes flush, so a flush leaves a dead cycle.
    always_ff @(posedge clk) begin
        if (rst)
            issueEn <= 1'b0;
        else
            issueEn <= accept;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.pc        <= pc;
            issue.op        <= info.op;
            issue.imm       <= imm;
            issue.rd        <= info.rd;
            issue.rs1       <= info.rs1;
            issue.rs2       <= info.rs2;
            issue.rs1Stat   <= rs1Stat;
            issue.rs2Stat   <= rs2Stat;
            issue.robTag    <= allocTag;
            issue.predTaken <= predTaken;
        end
    end

endmodule

`default_nettype wire

/* rtl/renameTable.sv */
`timescale 1ns/1ps
`default_nettype none

module renameTable
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              rdy,
    input  wire              flush,
    input  wire              accept,
    input  wire regName_t    rd,
    input  wire robTag_t     allocTag,
    input  wire regName_t    rs1,
    input  wire regName_t    rs2,
    input  wire              commitEn,
    input  wire commitInfo_t commit,
    output srcStatus_t       rs1Stat,
    output srcStatus_t       rs2Stat
);

    logic [31:0] busy;
    robTag_t     tagTable [32];

    always_ff @(posedge clk) begin
        if (rst || (rdy && flush)) begin
            busy <= '0;
        end else if (rdy) begin
            // Only the newest producer may clear the entry.
            if (commitEn && (tagTable[commit.rd] == commit.tag))
                busy[commit.rd] <= 1'b0;
            if (accept && (rd != '0))
                busy[rd] <= 1'b1;   // Wins over a commit to the same rd.
        end
    end

    always_ff @(posedge clk) begin
        if (accept && (rd != '0))
            tagTable[rd] <= allocTag;
    end

    // x0 is hardwired, so it never waits.
    assign rs1Stat.busy = (rs1 != '0) && busy[rs1];
    assign rs1Stat.tag  = tagTable[rs1];
    assign rs2Stat.busy = (rs2 != '0) && busy[rs2];
    assign rs2Stat.tag  = tagTable[rs2];

endmodule

`default_nettype wire

/* rtl/immGen.sv */
`timescale 1ns/1ps
`default_nettype none

module immGen
    import isaPkg::*;
(
    input  wire instWord_t inst,
    output imm_t           imm
);

    opcode_t opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            OpcOpImm, OpcLoad, OpcJalr:
                imm = {{21{inst[31]}}, inst[30:20]};
            OpcStore:
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            OpcBranch:   // Offset in halfwords, bit 0 is zero.
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OpcLui, OpcAuipc:
                imm = {inst[31:12], 12'b0};
            OpcJal:
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;   // R-type and unknown opcodes.
        endcase
    end

endmodule

`default_nettype wire

/* rtl/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecoder
    import isaPkg::*;
    import pipePkg::*;
(
    input  wire instWord_t   inst,
    output decodeInfo_t      info
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       funct7b30;   // Picks SUB, SRA and SRAI.

    assign opcode    = inst[6:0];
    assign funct3    = inst[14:12];
    assign funct7b30 = inst[30];

    always_comb begin
        info.rd  = inst[11:7];
        info.rs1 = inst[19:15];
        info.rs2 = inst[24:20];
        info.op  = OpNop;   // Anything unmatched stays a NOP.
        case (opcode)
            OpcLui:   info.op = OpLui;
            OpcAuipc: info.op = OpAuipc;
            OpcJal:   info.op = OpJal;
            OpcJalr:  info.op = OpJalr;
            OpcBranch: begin
                case (funct3)
                    3'b000:  info.op = OpBeq;
                    3'b001:  info.op = OpBne;
                    3'b100:  info.op = OpBlt;
                    3'b101:  info.op = OpBge;
                    3'b110:  info.op = OpBltu;
                    3'b111:  info.op = OpBgeu;
                    default: info.op = OpNop;
                endcase
            end
            OpcLoad: begin
                case (funct3)
                    3'b000:  info.op = OpLb;
                    3'b001:  info.op = OpLh;
                    3'b010:  info.op = OpLw;
                    3'b100:  info.op = OpLbu;
                    3'b101:  info.op = OpLhu;
                    default: info.op = OpNop;
                endcase
            end
            OpcStore: begin
                case (funct3)
                    3'b000:  info.op = OpSb;
                    3'b001:  info.op = OpSh;
                    3'b010:  info.op = OpSw;
                    default: info.op = OpNop;
                endcase
            end
            OpcOpImm: begin
                // Bit 30 belongs to the immediate except for shifts.
                case (funct3)
                    3'b000:  info.op = OpAddi;
                    3'b010:  info.op = OpSlti;
                    3'b011:  info.op = OpSltiu;
                    3'b100:  info.op = OpXori;
                    3'b110:  info.op = OpOri;
                    3'b111:  info.op = OpAndi;
                    3'b001:  info.op = funct7b30 ? OpNop : OpSlli;
                    default: info.op = funct7b30 ? OpSrai : OpSrli;
                endcase
            end
            OpcOp: begin
                case ({funct7b30, funct3})
                    4'b0000: info.op = OpAdd;
                    4'b1000: info.op = OpSub;
                    4'b0001: info.op = OpSll;
                    4'b0010: info.op = OpSlt;
                    4'b0011: info.op = OpSltu;
                    4'b0100: info.op = OpXor;
                    4'b0101: info.op = OpSrl;
                    4'b1101: info.op = OpSra;
                    4'b0110: info.op = OpOr;
                    4'b0111: info.op = OpAnd;
                    default: info.op = OpNop;
                endcase
            end
            default: info.op = OpNop;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/pipePkg.sv */
`default_nettype none

package pipePkg;
    import isaPkg::*;

    localparam int RobDepth = 8;
    localparam int TagWidth = 3;

    typedef logic [TagWidth-1:0] robTag_t;
    typedef logic [TagWidth:0]   robCount_t;   // Holds 0 to RobDepth.

    typedef struct packed {
        op_t      op;
        regName_t rd;
        regName_t rs1;
        regName_t rs2;
    } decodeInfo_t;

    typedef struct packed {
        logic    busy;
        robTag_t tag;   // Producer, valid while busy.
    } srcStatus_t;

    typedef struct packed {
        addr_t      pc;
        op_t        op;
        imm_t       imm;
        regName_t   rd;
        regName_t   rs1;
        regName_t   rs2;
        srcStatus_t rs1Stat;
        srcStatus_t rs2Stat;
        robTag_t    robTag;
        logic       predTaken;
    } issueBundle_t;

    typedef struct packed {
        regName_t rd;
        robTag_t  tag;
    } commitInfo_t;

endpackage

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int XLen         = 32;
    localparam int RegNameWidth = 5;
    localparam int OpcodeWidth  = 7;

    typedef logic [XLen-1:0]         instWord_t;
    typedef logic [XLen-1:0]         addr_t;
    typedef logic [XLen-1:0]         imm_t;
    typedef logic [RegNameWidth-1:0] regName_t;
    typedef logic [OpcodeWidth-1:0]  opcode_t;

    // Major RV32I opcodes.
    localparam opcode_t OpcLui    = 7'b0110111;
    localparam opcode_t OpcAuipc  = 7'b0010111;
    localparam opcode_t OpcJal    = 7'b1101111;
    localparam opcode_t OpcJalr   = 7'b1100111;
    localparam opcode_t OpcBranch = 7'b1100011;
    localparam opcode_t OpcLoad   = 7'b0000011;
    localparam opcode_t OpcStore  = 7'b0100011;
    localparam opcode_t OpcOpImm  = 7'b0010011;
    localparam opcode_t OpcOp     = 7'b0110011;

    // Operation codes handed to the reservation stations.
    typedef enum logic [5:0] {
        OpNop,
        OpLui, OpAuipc,
        OpJal, OpJalr,
        OpBeq, OpBne, OpBlt, OpBge, OpBltu, OpBgeu,
        OpLb, OpLh, OpLw, OpLbu, OpLhu,
        OpSb, OpSh, OpSw,
        OpAddi, OpSlti, OpSltiu, OpXori, OpOri, OpAndi,
        OpSlli, OpSrli, OpSrai,
        OpAdd, OpSub, OpSll, OpSlt, OpSltu,
        OpXor, OpSrl, OpSra, OpOr, OpAnd
    } op_t;

endpackage

`default_nettype wire
